// File: clkBoard.f
+incdir+include
design/clkPkg.sv
design/clkFuncIf.sv
design/clkFuncDecoder.sv
design/clkConfigRegs.sv
design/clkBurstCounter.sv
design/clkRunControl.sv
design/clkDiagRead.sv
design/clkBoard.sv
dv/clkBoardTb.sv

// File: design/clkBoard.sv
////////////////////////////////////////////////////////////////////////////
// Clock board diagnostic control
// Top level tying decoder, load registers, burst counter, run control
// and readback together
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "clk_defs.svh"

module clkBoard (
  input  wire logic                   CLK,
  input  wire logic                   FPGA_RESET,
  input  wire logic                   diagCtlFunc,
  input  wire logic                   diagLdFunc,
  input  wire logic                   diagRead,
  input  wire logic [`CLK_SEL_W-1:0]  diagSel,
  input  wire logic [`CLK_DATA_W-1:0] ebusData,
  output logic                        eboxClkEn,
  output logic                        running,
  output logic                        clkReset,
  output logic                        crmDis,
  output logic                        edpDis,
  output logic                        ctlDis,
  output logic [`CLK_READ_W-1:0]      readData,
  output logic                        readValid
);

  logic [1:0]              sourceSel;
  logic [`CLK_RATE_W-1:0]  rateSel;
  logic                    fmParCheck, cramParCheck, dramParCheck, fsParCheck;
  logic                    mboxCycleDis, respSim, arParCheck, errStopEn;
  logic [`CLK_BURST_W-1:0] burstCount;
  logic                    burstZero, burstStep, burstActive;

  clkFuncIf func_inst ();

  clkFuncDecoder clkFuncDecoder_inst (
    .CLK, .FPGA_RESET, .diagCtlFunc, .diagLdFunc, .diagSel,
    .ebusData (ebusData),
    .func     (func_inst.decoder)
  );

  clkConfigRegs clkConfigRegs_inst (
    .CLK, .FPGA_RESET,
    .func (func_inst.cfg),
    .sourceSel, .rateSel, .crmDis, .edpDis, .ctlDis,
    .fmParCheck, .cramParCheck, .dramParCheck, .fsParCheck,
    .mboxCycleDis, .respSim, .arParCheck, .errStopEn
  );

  clkBurstCounter clkBurstCounter_inst (
    .CLK, .FPGA_RESET,
    .func (func_inst.burstLd),
    .burstStep, .burstCount, .burstZero
  );

  clkRunControl clkRunControl_inst (
    .CLK, .FPGA_RESET,
    .func (func_inst.runCtl),
    .rateSel, .burstZero, .eboxClkEn, .burstStep, .running, .burstActive, .clkReset
  );

  clkDiagRead clkDiagRead_inst (
    .CLK, .FPGA_RESET, .diagRead, .diagSel, .burstCount,
    .running, .burstActive, .clkReset, .sourceSel, .rateSel,
    .crmDis, .edpDis, .ctlDis,
    .fmParCheck, .cramParCheck, .dramParCheck, .fsParCheck,
    .mboxCycleDis, .respSim, .arParCheck, .errStopEn,
    .readData, .readValid
  );

endmodule

`default_nettype wire

// File: design/clkBurstCounter.sv
////////////////////////////////////////////////////////////////////////////
// Burst counter, loaded a nibble at a time and counted down per pulse
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "clk_defs.svh"

module clkBurstCounter (
  input  wire logic                    CLK,
  input  wire logic                    FPGA_RESET,
  clkFuncIf.burstLd                    func,
  input  wire logic                    burstStep,
  output logic [`CLK_BURST_W-1:0]      burstCount,
  output logic                         burstZero
);

  localparam int HI = `CLK_BURST_W - 1;
  localparam int LO = `CLK_DATA_W;

  assign burstZero = (burstCount == '0);

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      burstCount <= '0;
    end else if (func.ldBurstLo || func.ldBurstHi) begin
      // Loads win over a step in the same cycle
      if (func.ldBurstLo) begin
        burstCount[LO-1:0] <= func.data.raw;
      end
      if (func.ldBurstHi) begin
        burstCount[HI:LO] <= func.data.raw;
      end
    end else if (burstStep && !burstZero) begin
      burstCount <= burstCount - 1'b1;   // Holds at zero
    end
  end

endmodule

`default_nettype wire

// File: design/clkConfigRegs.sv
////////////////////////////////////////////////////////////////////////////
// Load function registers
// Source/rate select, section disables, parity checks and misc controls
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "clk_defs.svh"

module clkConfigRegs (
  input  wire logic                   CLK,
  input  wire logic                   FPGA_RESET,
  clkFuncIf.cfg                       func,
  output logic [1:0]                  sourceSel,
  output logic [`CLK_RATE_W-1:0]      rateSel,
  output logic                        crmDis,
  output logic                        edpDis,
  output logic                        ctlDis,
  output logic                        fmParCheck,
  output logic                        cramParCheck,
  output logic                        dramParCheck,
  output logic                        fsParCheck,
  output logic                        mboxCycleDis,
  output logic                        respSim,
  output logic                        arParCheck,
  output logic                        errStopEn
);

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      sourceSel <= '0;
      rateSel   <= '0;
      crmDis    <= 1'b0;
      edpDis    <= 1'b0;
      ctlDis    <= 1'b0;
      {fmParCheck, cramParCheck, dramParCheck, fsParCheck} <= '0;
      {mboxCycleDis, respSim, arParCheck, errStopEn}       <= '0;
    end else begin
      if (func.ldSelect) begin   // Source select is only stored here
        sourceSel <= func.data.sel.sourceSel;
        rateSel   <= func.data.sel.rateSel;
      end
      if (func.ldDisable) begin
        crmDis <= func.data.dis.crmDis;
        edpDis <= func.data.dis.edpDis;
        ctlDis <= func.data.dis.ctlDis;
      end
      if (func.ldParity) begin
        fmParCheck   <= func.data.par.fmParCheck;
        cramParCheck <= func.data.par.cramParCheck;
        dramParCheck <= func.data.par.dramParCheck;
        fsParCheck   <= func.data.par.fsParCheck;
      end
      if (func.ldMisc) begin
        mboxCycleDis <= func.data.misc.mboxCycleDis;
        respSim      <= func.data.misc.respSim;
        arParCheck   <= func.data.misc.arParCheck;
        errStopEn    <= func.data.misc.errStopEn;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/clkDiagRead.sv
////////////////////////////////////////////////////////////////////////////
// Diagnostic readback
// Picks one 6-bit status word by select code and returns it registered
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "clk_defs.svh"

module clkDiagRead (
  input  wire logic                    CLK,
  input  wire logic                    FPGA_RESET,
  input  wire logic                    diagRead,
  input  wire logic [`CLK_SEL_W-1:0]   diagSel,
  input  wire logic [`CLK_BURST_W-1:0] burstCount,
  input  wire logic                    running,
  input  wire logic                    burstActive,
  input  wire logic                    clkReset,
  input  wire logic [1:0]              sourceSel,
  input  wire logic [`CLK_RATE_W-1:0]  rateSel,
  input  wire logic                    crmDis,
  input  wire logic                    edpDis,
  input  wire logic                    ctlDis,
  input  wire logic                    fmParCheck,
  input  wire logic                    cramParCheck,
  input  wire logic                    dramParCheck,
  input  wire logic                    fsParCheck,
  input  wire logic                    mboxCycleDis,
  input  wire logic                    respSim,
  input  wire logic                    arParCheck,
  input  wire logic                    errStopEn,
  output logic [`CLK_READ_W-1:0]       readData,
  output logic                         readValid
);

  logic                   readReq;
  logic [`CLK_SEL_W-1:0]  readSel;
  logic [`CLK_READ_W-1:0] readWord;

  always_comb begin
    case (readSel)
      3'd0:    readWord = burstCount[7:2];
      3'd1:    readWord = {burstCount[1:0], running, burstActive, clkReset, 1'b0};
      3'd2:    readWord = {2'b00, sourceSel, rateSel};
      3'd3:    readWord = {3'b000, crmDis, edpDis, ctlDis};
      3'd4:    readWord = {2'b00, fmParCheck, cramParCheck, dramParCheck, fsParCheck};
      3'd5:    readWord = {2'b00, mboxCycleDis, respSim, arParCheck, errStopEn};
      default: readWord = '0;   // Selects 6 and 7 are empty
    endcase
  end

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      readReq   <= 1'b0;
      readSel   <= '0;
      readValid <= 1'b0;
      readData  <= '0;
    end else begin
      readReq   <= diagRead;
      readSel   <= diagSel;
      readValid <= readReq;
      if (readReq) begin
        readData <= readWord;   // Holds between reads
      end
    end
  end

endmodule

`default_nettype wire

// File: design/clkFuncDecoder.sv
////////////////////////////////////////////////////////////////////////////
// Diagnostic function decoder
// Captures the EBUS function request, then decodes it into one-hot strobes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "clk_defs.svh"

module clkFuncDecoder
  import clkPkg::*;
(
  input  wire logic                  CLK,
  input  wire logic                  FPGA_RESET,
  input  wire logic                  diagCtlFunc,
  input  wire logic                  diagLdFunc,
  input  wire logic [`CLK_SEL_W-1:0] diagSel,
  input  wire loadWordT              ebusData,
  clkFuncIf.decoder                  func
);

  logic                  ctlReq;   // Captured request
  logic                  ldReq;
  logic [`CLK_SEL_W-1:0] selQ;
  loadWordT              dataQ;

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      ctlReq <= 1'b0;
      ldReq  <= 1'b0;
    end else begin
      ctlReq <= diagCtlFunc;
      ldReq  <= diagLdFunc & ~diagCtlFunc;   // Control group wins
    end
  end

  always_ff @(posedge CLK) begin
    selQ      <= diagSel;
    dataQ     <= ebusData;
    func.data <= dataQ;   // Travels with its strobe
  end

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      {func.start, func.singleStep, func.burst}                 <= '0;
      {func.clrReset, func.setReset, func.ctlAny}               <= '0;
      {func.ldBurstLo, func.ldBurstHi, func.ldSelect}           <= '0;
      {func.ldDisable, func.ldParity, func.ldMisc}              <= '0;
    end else begin
      func.ctlAny     <= ctlReq;
      func.start      <= ctlReq && selQ == `CLK_FN_START;
      func.singleStep <= ctlReq && selQ == `CLK_FN_SSTEP;
      func.burst      <= ctlReq && selQ == `CLK_FN_BURST;
      func.clrReset   <= ctlReq && selQ == `CLK_FN_CLR_RESET;
      func.setReset   <= ctlReq && selQ == `CLK_FN_SET_RESET;
      // Load codes 0 and 1 have no strobe
      func.ldBurstLo  <= ldReq && selQ == `CLK_LD_BURST_LO;
      func.ldBurstHi  <= ldReq && selQ == `CLK_LD_BURST_HI;
      func.ldSelect   <= ldReq && selQ == `CLK_LD_SELECT;
      func.ldDisable  <= ldReq && selQ == `CLK_LD_DISABLE;
      func.ldParity   <= ldReq && selQ == `CLK_LD_PARITY;
      func.ldMisc     <= ldReq && selQ == `CLK_LD_MISC;
    end
  end

endmodule

`default_nettype wire

// File: design/clkFuncIf.sv
////////////////////////////////////////////////////////////////////////////
// Decoded diagnostic function strobes and their load data word
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface clkFuncIf
  import clkPkg::*;
();

  logic     start, singleStep, burst;  // Control group
  logic     clrReset, setReset;
  logic     ctlAny;                    // Any control code, even unused ones
  logic     ldBurstLo, ldBurstHi;      // Load group
  logic     ldSelect, ldDisable, ldParity, ldMisc;
  loadWordT data;

  modport decoder (output start, singleStep, burst, clrReset, setReset, ctlAny,
                   output ldBurstLo, ldBurstHi, ldSelect, ldDisable, ldParity, ldMisc,
                   output data);

  modport runCtl (input start, singleStep, burst, clrReset, setReset, ctlAny);

  modport cfg (input ldSelect, ldDisable, ldParity, ldMisc, data);

  modport burstLd (input ldBurstLo, ldBurstHi, data);

endinterface

`default_nettype wire

// File: design/clkPkg.sv
////////////////////////////////////////////////////////////////////////////
// Clock board types
// The load data nibble decodes differently for each load function
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`include "clk_defs.svh"

package clkPkg;

  // Bit order follows the EBUS, bit 32 is the MSB of each view
  typedef union packed {
    logic [`CLK_DATA_W-1:0] raw;
    struct packed {
      logic [1:0]             sourceSel;
      logic [`CLK_RATE_W-1:0] rateSel;
    } sel;
    struct packed {
      logic spare;       // Bit 32 unused
      logic crmDis;
      logic edpDis;
      logic ctlDis;
    } dis;
    struct packed {
      logic fmParCheck;
      logic cramParCheck;
      logic dramParCheck;
      logic fsParCheck;
    } par;
    struct packed {
      logic mboxCycleDis;
      logic respSim;
      logic arParCheck;
      logic errStopEn;
    } misc;
  } loadWordT;

endpackage

`default_nettype wire

// File: design/clkRunControl.sv
////////////////////////////////////////////////////////////////////////////
// EBOX run control
// Start, single step and burst modes, the rate divider that paces
// the clock enable, and the clock board reset flag
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "clk_defs.svh"

module clkRunControl (
  input  wire logic                   CLK,
  input  wire logic                   FPGA_RESET,
  clkFuncIf.runCtl                    func,
  input  wire logic [`CLK_RATE_W-1:0] rateSel,
  input  wire logic                   burstZero,
  output logic                        eboxClkEn,
  output logic                        burstStep,
  output logic                        running,
  output logic                        burstActive,
  output logic                        clkReset
);

  logic                   go;          // Free running
  logic                   ssPending;   // One pulse still owed
  logic [`CLK_RATE_W-1:0] divCnt;
  logic                   tick;

  // Compare with >= so a smaller rate picked mid-count still ticks
  assign tick = (divCnt >= rateSel);

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      divCnt <= '0;
    end else if (func.ctlAny || tick) begin   // Restart on any function
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + 1'b1;
    end
  end

  // Burst pulses only while there is count left
  assign burstStep = tick & burstActive & ~burstZero;
  assign eboxClkEn = (tick & (go | ssPending)) | burstStep;
  assign running   = go | burstActive | ssPending;

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      go          <= 1'b0;
      burstActive <= 1'b0;
      ssPending   <= 1'b0;
    end else if (func.ctlAny) begin
      // Every control code stops the clock, then starts the mode it names
      go          <= func.start;
      burstActive <= func.burst;
      ssPending   <= func.singleStep;
    end else begin
      if (tick) begin
        ssPending <= 1'b0;
      end
      if (burstActive && burstZero) begin   // Count ran out
        burstActive <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      clkReset <= 1'b0;
    end else if (func.setReset) begin
      clkReset <= 1'b1;
    end else if (func.clrReset) begin
      clkReset <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: dv/clkBoardTb.sv
////////////////////////////////////////////////////////////////////////////
// Clock board testbench
// Directed tests of loads, readback, run modes and the reset flag
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "clk_defs.svh"

module clkBoardTb;

  localparam int MAX_CYCLES = 3000;   // Full suite runs well under 1000

  logic                   CLK, FPGA_RESET;
  logic                   diagCtlFunc, diagLdFunc, diagRead;
  logic [`CLK_SEL_W-1:0]  diagSel;
  logic [`CLK_DATA_W-1:0] ebusData;
  logic                   eboxClkEn, running, clkReset, crmDis, edpDis, ctlDis;
  logic [`CLK_READ_W-1:0] readData;
  logic                   readValid;

  // Expected board state, kept from the load and control rules
  logic [1:0] shSource, shRate;
  logic [2:0] shDis;
  logic [3:0] shPar, shMisc;
  logic [7:0] shCount;
  logic       shRunning, shClkReset;

  int errorCount, testsRun, testsFailed, cycleCount;

  clkBoard clkBoard_inst (
    .CLK, .FPGA_RESET, .diagCtlFunc, .diagLdFunc, .diagRead, .diagSel, .ebusData,
    .eboxClkEn, .running, .clkReset, .crmDis, .edpDis, .ctlDis, .readData, .readValid
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;   // 40 ns period
  end

  always @(posedge CLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= MAX_CYCLES) begin
      $display("Timeout: run went past %0d cycles", MAX_CYCLES);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: expected 0x%0h, got 0x%0h", name, exp, got);
      errorCount++;
    end
  endtask

  task automatic closeTest(input string name, input int startErrors);
    testsRun++;
    if (errorCount == startErrors) begin
      $display("[PASS] %s", name);
    end else begin
      testsFailed++;
      $display("[FAIL] %s: %0d errors", name, errorCount - startErrors);
    end
  endtask

  // Readback layout, MSB first
  function automatic logic [5:0] expectedWord(input logic [2:0] sel);
    case (sel)
      3'd0:    return shCount[7:2];
      3'd1:    return {shCount[1:0], shRunning, 1'b0, shClkReset, 1'b0};  // Never read mid-burst
      3'd2:    return {2'b00, shSource, shRate};
      3'd3:    return {3'b000, shDis};
      3'd4:    return {2'b00, shPar};
      3'd5:    return {2'b00, shMisc};
      default: return 6'h00;
    endcase
  endfunction

  task automatic sendCtl(input logic [2:0] code);
    @(posedge CLK);
    diagCtlFunc <= 1'b1;
    diagSel     <= code;
    @(posedge CLK);
    diagCtlFunc <= 1'b0;
  endtask

  task automatic sendLoad(input logic [2:0] code, input logic [3:0] data);
    @(posedge CLK);
    diagLdFunc <= 1'b1;
    diagSel    <= code;
    ebusData   <= data;
    @(posedge CLK);
    diagLdFunc <= 1'b0;
    case (code)
      `CLK_LD_BURST_LO: shCount[3:0] = data;
      `CLK_LD_BURST_HI: shCount[7:4] = data;
      `CLK_LD_SELECT:   {shSource, shRate} = data;
      `CLK_LD_DISABLE:  shDis = data[2:0];   // Bit 32 is spare
      `CLK_LD_PARITY:   shPar = data;
      `CLK_LD_MISC:     shMisc = data;
      default: ;
    endcase
    repeat (2) @(posedge CLK);   // Register is written two edges after the strobe
  endtask

  task automatic verifyRead(input logic [2:0] sel);
    int waited;
    @(posedge CLK);
    diagRead <= 1'b1;
    diagSel  <= sel;
    @(posedge CLK);
    diagRead <= 1'b0;
    waited = 0;
    do begin
      @(negedge CLK);
      waited++;
    end while (!readValid && waited < 8);
    if (!readValid) begin
      $display("No readValid within 8 cycles of a read of select %0d", sel);
      errorCount++;
    end else begin
      compareValue($sformatf("readData sel %0d", sel), readData, expectedWord(sel));
    end
  endtask

  task automatic countPulses(input int cycles, output int pulses);
    pulses = 0;
    repeat (cycles) begin
      @(negedge CLK);
      if (eboxClkEn) begin
        pulses++;
      end
    end
  endtask

  // Cycles up to the next enable pulse, 16 when none shows up
  task automatic measureGap(output int gap);
    gap = 0;
    do begin
      @(negedge CLK);
      gap++;
    end while (!eboxClkEn && gap < 16);
  endtask

  task automatic configLoadTest();
    int startErrors;
    startErrors = errorCount;
    repeat (3) begin
      for (int code = 4; code <= 7; code++) begin
        sendLoad(3'(code), 4'($urandom));
      end
      for (int sel = 2; sel <= 5; sel++) begin
        verifyRead(3'(sel));
      end
      compareValue("crmDis", crmDis, shDis[2]);
      compareValue("edpDis", edpDis, shDis[1]);
      compareValue("ctlDis", ctlDis, shDis[0]);
    end
    closeTest("configLoad", startErrors);
  endtask

  task automatic burstCountTest();
    int startErrors;
    startErrors = errorCount;
    sendLoad(`CLK_LD_BURST_LO, 4'($urandom));
    sendLoad(`CLK_LD_BURST_HI, 4'($urandom));
    verifyRead(3'd0);
    verifyRead(3'd1);
    closeTest("burstCount", startErrors);
  endtask

  task automatic startRunTest();
    int startErrors, gap, pulses;
    startErrors = errorCount;
    for (int rate = 0; rate < 4; rate++) begin
      sendLoad(`CLK_LD_SELECT, {2'($urandom), 2'(rate)});
      sendCtl(`CLK_FN_START);
      shRunning = 1'b1;
      measureGap(gap);
      if (!eboxClkEn) begin
        $display("No eboxClkEn pulse after start at rateSel %0d", rate);
        errorCount++;
      end
      repeat (4) begin
        measureGap(gap);
        compareValue($sformatf("eboxClkEn spacing at rateSel %0d", rate), gap, rate + 1);
      end
      verifyRead(3'd1);
      compareValue("running", running, 1);
      sendCtl(3'd3);   // Unused control code just stops the clock
      shRunning = 1'b0;
      repeat (2) @(posedge CLK);
      countPulses(12, pulses);
      compareValue("eboxClkEn pulses after stop", pulses, 0);
      verifyRead(3'd1);
      compareValue("running", running, 0);
    end
    closeTest("startRun", startErrors);
  endtask

  task automatic singleStepTest();
    int startErrors, pulses;
    startErrors = errorCount;
    repeat (2) begin
      sendLoad(`CLK_LD_SELECT, 4'($urandom));
      sendCtl(`CLK_FN_SSTEP);
      countPulses(10, pulses);
      compareValue("eboxClkEn pulses in single step", pulses, 1);
      countPulses(20, pulses);
      compareValue("eboxClkEn pulses after single step", pulses, 0);
      verifyRead(3'd1);
    end
    closeTest("singleStep", startErrors);
  endtask

  task automatic burstRunTest();
    int startErrors, k, rate, pulses;
    startErrors = errorCount;
    for (int i = 0; i < 4; i++) begin
      k = (i == 0) ? 1 : (i == 1) ? 20 : (i == 2) ? 2 + int'($urandom % 18) : 0;
      rate = int'($urandom % 4);
      sendLoad(`CLK_LD_SELECT, {2'($urandom), 2'(rate)});
      sendLoad(`CLK_LD_BURST_LO, 4'(k));
      sendLoad(`CLK_LD_BURST_HI, 4'(k >> 4));
      sendCtl(`CLK_FN_BURST);
      countPulses(k * (rate + 1) + 8, pulses);   // Room for the pipeline delay
      compareValue($sformatf("eboxClkEn pulses in burst of %0d", k), pulses, k);
      countPulses(20, pulses);
      compareValue("eboxClkEn pulses after burst", pulses, 0);
      shCount = 8'h00;
      verifyRead(3'd0);
      verifyRead(3'd1);
    end
    closeTest("burstRun", startErrors);
  endtask

  task automatic resetFlagTest();
    int startErrors;
    startErrors = errorCount;
    sendCtl(`CLK_FN_SET_RESET);
    repeat (3) @(negedge CLK);
    shClkReset = 1'b1;
    compareValue("clkReset", clkReset, 1);
    verifyRead(3'd1);
    sendCtl(`CLK_FN_CLR_RESET);
    repeat (3) @(negedge CLK);
    shClkReset = 1'b0;
    compareValue("clkReset", clkReset, 0);
    verifyRead(3'd1);
    sendLoad(3'd0, 4'($urandom));   // Load codes with no register
    sendLoad(3'd1, 4'($urandom));
    for (int sel = 0; sel < 8; sel++) begin
      verifyRead(3'(sel));
    end
    closeTest("resetFlag", startErrors);
  endtask

  initial begin
    void'($urandom(16480));
    FPGA_RESET  = 1'b1;
    diagCtlFunc = 1'b0;
    diagLdFunc  = 1'b0;
    diagRead    = 1'b0;
    diagSel     = '0;
    ebusData    = '0;
    {shSource, shRate, shDis, shPar, shMisc, shCount} = '0;
    shRunning  = 1'b0;
    shClkReset = 1'b0;
    repeat (10) @(posedge CLK);
    FPGA_RESET <= 1'b0;
    configLoadTest();
    burstCountTest();
    startRunTest();
    singleStepTest();
    burstRunTest();
    resetFlagTest();
    $display("Summary: %0d tests run, %0d failed, %0d errors",
             testsRun, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: include/clk_defs.svh
////////////////////////////////////////////////////////////////////////////
// Clock board field widths and diagnostic function codes
////////////////////////////////////////////////////////////////////////////
`ifndef CLK_DEFS_SVH
`define CLK_DEFS_SVH

`define CLK_SEL_W    3   // Function and readback select
`define CLK_DATA_W   4   // EBUS bits 32-35
`define CLK_READ_W   6   // Diagnostic readback word
`define CLK_BURST_W  8
`define CLK_RATE_W   2

// Control group codes
`define CLK_FN_START      3'd1
`define CLK_FN_SSTEP      3'd2
`define CLK_FN_BURST      3'd5
`define CLK_FN_CLR_RESET  3'd6
`define CLK_FN_SET_RESET  3'd7

// Load group codes
`define CLK_LD_BURST_LO   3'd2
`define CLK_LD_BURST_HI   3'd3
`define CLK_LD_SELECT     3'd4
`define CLK_LD_DISABLE    3'd5
`define CLK_LD_PARITY     3'd6
`define CLK_LD_MISC       3'd7

`endif

// File: run.sh
#!/usr/bin/env bash
# Build and run the clock board testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing -Wno-fatal -f clkBoard.f \
  --top-module clkBoardTb -o clkBoardSim

./obj_dir/clkBoardSim | tee "$LOG"

if grep -q "^Test OK$" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG"
  exit 1
fi
